/* rtl/bus_decoder.sv */
`timescale 1ns/10ps

module bus_decoder
   import soc_pkg::*;
(
   input  logic  clk,
   input  logic  arst_n,
   input  addr_t awaddr,
   input  logic  awvalid,
   output logic  awready,
   input  data_t wdata,
   input  strb_t wstrb,
   input  logic  wvalid,
   output logic  wready,
   output resp_t bresp,
   output logic  bvalid,
   input  logic  bready,
   input  addr_t araddr,
   input  logic  arvalid,
   output logic  arready,
   output data_t rdata,
   output resp_t rresp,
   output logic  rvalid,
   input  logic  rready,
   output addr_t ram_awaddr,
   output logic  ram_awvalid,
   input  logic  ram_awready,
   output data_t ram_wdata,
   output strb_t ram_wstrb,
   output logic  ram_wvalid,
   input  logic  ram_wready,
   input  resp_t ram_bresp,
   input  logic  ram_bvalid,
   output logic  ram_bready,
   output addr_t ram_araddr,
   output logic  ram_arvalid,
   input  logic  ram_arready,
   input  data_t ram_rdata,
   input  resp_t ram_rresp,
   input  logic  ram_rvalid,
   output logic  ram_rready,
   output addr_t txt_awaddr,
   output logic  txt_awvalid,
   input  logic  txt_awready,
   output data_t txt_wdata,
   output strb_t txt_wstrb,
   output logic  txt_wvalid,
   input  logic  txt_wready,
   input  resp_t txt_bresp,
   input  logic  txt_bvalid,
   output logic  txt_bready
);

   typedef enum logic [2:0] {W_IDLE, W_RAM, W_TXT, W_ERR_ACC, W_ERR_RESP} wr_state_t;
   typedef enum logic [1:0] {R_IDLE, R_RAM, R_SELF_ACC, R_SELF_RESP} rd_state_t;

   wr_state_t w_state;
   rd_state_t r_state;
   resp_t     self_rresp;
   logic      w_hit_ram;
   logic      w_hit_txt;
   logic      r_hit_ram;
   logic      r_hit_txt;
   logic      w_sel_ram;
   logic      w_sel_txt;
   logic      r_sel_ram;

   function automatic logic in_window(input addr_t addr, input addr_t base, input int bits);
      return (addr >> bits) == (base >> bits);
   endfunction

   assign w_hit_ram = in_window(awaddr, RAM_BASE, RAM_ADDR_BITS);
   assign w_hit_txt = in_window(awaddr, TEXT_BASE, TEXT_ADDR_BITS);
   assign r_hit_ram = in_window(araddr, RAM_BASE, RAM_ADDR_BITS);
   assign r_hit_txt = in_window(araddr, TEXT_BASE, TEXT_ADDR_BITS);

   // decode live while idle, then follow the latched route
   assign w_sel_ram = (w_state == W_IDLE) ? w_hit_ram : (w_state == W_RAM);
   assign w_sel_txt = (w_state == W_IDLE) ? w_hit_txt : (w_state == W_TXT);
   assign r_sel_ram = (r_state == R_IDLE) ? r_hit_ram : (r_state == R_RAM);

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         w_state <= W_IDLE;
      end else begin
         case (w_state)
            W_IDLE:
               if (awvalid && wvalid)
                  w_state <= w_hit_ram ? W_RAM : (w_hit_txt ? W_TXT : W_ERR_ACC);
            W_RAM:
               if (ram_bvalid && bready)
                  w_state <= W_IDLE;
            W_TXT:
               if (txt_bvalid && bready)
                  w_state <= W_IDLE;
            W_ERR_ACC:
               w_state <= W_ERR_RESP;
            W_ERR_RESP:
               if (bready)
                  w_state <= W_IDLE;
            default:
               w_state <= W_IDLE;
         endcase
      end
   end

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         r_state    <= R_IDLE;
         self_rresp <= RESP_OKAY;
      end else begin
         case (r_state)
            R_IDLE:
               if (arvalid) begin
                  r_state    <= r_hit_ram ? R_RAM : R_SELF_ACC;
                  // text reads answer zero with okay
                  self_rresp <= r_hit_txt ? RESP_OKAY : RESP_DECERR;
               end
            R_RAM:
               if (ram_rvalid && rready)
                  r_state <= R_IDLE;
            R_SELF_ACC:
               r_state <= R_SELF_RESP;
            R_SELF_RESP:
               if (rready)
                  r_state <= R_IDLE;
            default:
               r_state <= R_IDLE;
         endcase
      end
   end

   assign ram_awaddr  = awaddr;
   assign ram_wdata   = wdata;
   assign ram_wstrb   = wstrb;
   assign ram_awvalid = awvalid && w_sel_ram;
   assign ram_wvalid  = wvalid && w_sel_ram;
   assign ram_bready  = bready && (w_state == W_RAM);

   assign txt_awaddr  = awaddr;
   assign txt_wdata   = wdata;
   assign txt_wstrb   = wstrb;
   assign txt_awvalid = awvalid && w_sel_txt;
   assign txt_wvalid  = wvalid && w_sel_txt;
   assign txt_bready  = bready && (w_state == W_TXT);

   assign ram_araddr  = araddr;
   assign ram_arvalid = arvalid && r_sel_ram;
   assign ram_rready  = rready && (r_state == R_RAM);

   // back to the master
   assign awready = (w_state == W_RAM) ? ram_awready :
                    (w_state == W_TXT) ? txt_awready : (w_state == W_ERR_ACC);
   assign wready  = (w_state == W_RAM) ? ram_wready :
                    (w_state == W_TXT) ? txt_wready : (w_state == W_ERR_ACC);
   assign bvalid  = (w_state == W_RAM) ? ram_bvalid :
                    (w_state == W_TXT) ? txt_bvalid : (w_state == W_ERR_RESP);
   assign bresp   = (w_state == W_RAM) ? ram_bresp :
                    (w_state == W_TXT) ? txt_bresp :
                    (w_state == W_ERR_RESP) ? RESP_DECERR : RESP_OKAY;

   assign arready = (r_state == R_RAM) ? ram_arready : (r_state == R_SELF_ACC);
   assign rvalid  = (r_state == R_RAM) ? ram_rvalid : (r_state == R_SELF_RESP);
   assign rdata   = (r_state == R_RAM) ? ram_rdata : '0;
   assign rresp   = (r_state == R_RAM) ? ram_rresp : self_rresp;

endmodule

/* rtl/soc_pkg.sv */
package soc_pkg;

   // bus payload types
   typedef logic [31:0] addr_t;
   typedef logic [31:0] data_t;
   typedef logic [3:0]  strb_t;
   typedef logic [1:0]  resp_t;

   // pixel colour, one bit each for r, g, b
   typedef logic [2:0]  rgb_t;

   localparam resp_t RESP_OKAY   = 2'd0;
   localparam resp_t RESP_DECERR = 2'd3;

   // main ram, 32 KiB
   localparam addr_t RAM_BASE      = 32'h1c000000;
   localparam int    RAM_ADDR_BITS = 15;

   // text buffer, 2048 words
   localparam addr_t TEXT_BASE      = 32'h00010000;
   localparam int    TEXT_ADDR_BITS = 13;

endpackage

/* rtl/soc_top.sv */
`timescale 1ns/10ps

module soc_top
   import soc_pkg::*;
#(
   parameter int COLS      = 80,
   parameter int ROWS      = 25,
   parameter int CELL_W    = 8,
   parameter int CELL_H    = 16,
   parameter int H_VISIBLE = 640,
   parameter int H_FRONT   = 16,
   parameter int H_SYNC    = 96,
   parameter int H_BACK    = 48,
   parameter int V_VISIBLE = 480,
   parameter int V_FRONT   = 10,
   parameter int V_SYNC    = 2,
   parameter int V_BACK    = 33
) (
   input  logic  clk,
   input  logic  arst_n,
   input  addr_t awaddr,
   input  logic  awvalid,
   output logic  awready,
   input  data_t wdata,
   input  strb_t wstrb,
   input  logic  wvalid,
   output logic  wready,
   output resp_t bresp,
   output logic  bvalid,
   input  logic  bready,
   input  addr_t araddr,
   input  logic  arvalid,
   output logic  arready,
   output data_t rdata,
   output resp_t rresp,
   output logic  rvalid,
   input  logic  rready,
   output rgb_t  vga_rgb,
   output logic  vga_hsync,
   output logic  vga_vsync
);

   localparam int RAM_WORDS_LOG2 = RAM_ADDR_BITS - 2;
   localparam int TXT_WORDS_LOG2 = TEXT_ADDR_BITS - 2;

   addr_t ram_awaddr;
   logic  ram_awvalid;
   logic  ram_awready;
   data_t ram_wdata;
   strb_t ram_wstrb;
   logic  ram_wvalid;
   logic  ram_wready;
   resp_t ram_bresp;
   logic  ram_bvalid;
   logic  ram_bready;
   addr_t ram_araddr;
   logic  ram_arvalid;
   logic  ram_arready;
   data_t ram_rdata;
   resp_t ram_rresp;
   logic  ram_rvalid;
   logic  ram_rready;

   addr_t txt_awaddr;
   logic  txt_awvalid;
   logic  txt_awready;
   data_t txt_wdata;
   strb_t txt_wstrb;
   logic  txt_wvalid;
   logic  txt_wready;
   resp_t txt_bresp;
   logic  txt_bvalid;
   logic  txt_bready;

   // main ram ports
   logic [RAM_WORDS_LOG2-1:0] ram_wr_index;
   data_t                     ram_wr_data;
   strb_t                     ram_wr_be;
   logic                      ram_wr_en;
   logic [RAM_WORDS_LOG2-1:0] ram_rd_index;
   logic                      ram_rd_en;
   data_t                     ram_rd_data;

   // text buffer write side
   logic [TXT_WORDS_LOG2-1:0] txt_index;
   data_t                     txt_data;
   strb_t                     txt_be;
   logic                      txt_we;

   bus_decoder u_decoder (
      .clk         (clk),
      .arst_n      (arst_n),
      .awaddr      (awaddr),
      .awvalid     (awvalid),
      .awready     (awready),
      .wdata       (wdata),
      .wstrb       (wstrb),
      .wvalid      (wvalid),
      .wready      (wready),
      .bresp       (bresp),
      .bvalid      (bvalid),
      .bready      (bready),
      .araddr      (araddr),
      .arvalid     (arvalid),
      .arready     (arready),
      .rdata       (rdata),
      .rresp       (rresp),
      .rvalid      (rvalid),
      .rready      (rready),
      .ram_awaddr  (ram_awaddr),
      .ram_awvalid (ram_awvalid),
      .ram_awready (ram_awready),
      .ram_wdata   (ram_wdata),
      .ram_wstrb   (ram_wstrb),
      .ram_wvalid  (ram_wvalid),
      .ram_wready  (ram_wready),
      .ram_bresp   (ram_bresp),
      .ram_bvalid  (ram_bvalid),
      .ram_bready  (ram_bready),
      .ram_araddr  (ram_araddr),
      .ram_arvalid (ram_arvalid),
      .ram_arready (ram_arready),
      .ram_rdata   (ram_rdata),
      .ram_rresp   (ram_rresp),
      .ram_rvalid  (ram_rvalid),
      .ram_rready  (ram_rready),
      .txt_awaddr  (txt_awaddr),
      .txt_awvalid (txt_awvalid),
      .txt_awready (txt_awready),
      .txt_wdata   (txt_wdata),
      .txt_wstrb   (txt_wstrb),
      .txt_wvalid  (txt_wvalid),
      .txt_wready  (txt_wready),
      .txt_bresp   (txt_bresp),
      .txt_bvalid  (txt_bvalid),
      .txt_bready  (txt_bready)
   );

   sram_write_port #(.INDEX_BITS(RAM_WORDS_LOG2)) u_ram_wr (
      .clk       (clk),
      .arst_n    (arst_n),
      .awaddr    (ram_awaddr),
      .awvalid   (ram_awvalid),
      .awready   (ram_awready),
      .wdata     (ram_wdata),
      .wstrb     (ram_wstrb),
      .wvalid    (ram_wvalid),
      .wready    (ram_wready),
      .bresp     (ram_bresp),
      .bvalid    (ram_bvalid),
      .bready    (ram_bready),
      .mem_index (ram_wr_index),
      .mem_wdata (ram_wr_data),
      .mem_be    (ram_wr_be),
      .mem_we    (ram_wr_en)
   );

   sram_read_port #(.INDEX_BITS(RAM_WORDS_LOG2)) u_ram_rd (
      .clk       (clk),
      .arst_n    (arst_n),
      .araddr    (ram_araddr),
      .arvalid   (ram_arvalid),
      .arready   (ram_arready),
      .rdata     (ram_rdata),
      .rresp     (ram_rresp),
      .rvalid    (ram_rvalid),
      .rready    (ram_rready),
      .mem_index (ram_rd_index),
      .mem_re    (ram_rd_en),
      .mem_rdata (ram_rd_data)
   );

   sram #(.WORDS_LOG2(RAM_WORDS_LOG2)) u_ram (
      .clk      (clk),
      .wr_index (ram_wr_index),
      .wr_data  (ram_wr_data),
      .wr_be    (ram_wr_be),
      .wr_en    (ram_wr_en),
      .rd_index (ram_rd_index),
      .rd_en    (ram_rd_en),
      .rd_data  (ram_rd_data)
   );

   sram_write_port #(.INDEX_BITS(TXT_WORDS_LOG2)) u_txt_wr (
      .clk       (clk),
      .arst_n    (arst_n),
      .awaddr    (txt_awaddr),
      .awvalid   (txt_awvalid),
      .awready   (txt_awready),
      .wdata     (txt_wdata),
      .wstrb     (txt_wstrb),
      .wvalid    (txt_wvalid),
      .wready    (txt_wready),
      .bresp     (txt_bresp),
      .bvalid    (txt_bvalid),
      .bready    (txt_bready),
      .mem_index (txt_index),
      .mem_wdata (txt_data),
      .mem_be    (txt_be),
      .mem_we    (txt_we)
   );

   vga_text_scan #(
      .COLS      (COLS),
      .ROWS      (ROWS),
      .CELL_W    (CELL_W),
      .CELL_H    (CELL_H),
      .H_VISIBLE (H_VISIBLE),
      .H_FRONT   (H_FRONT),
      .H_SYNC    (H_SYNC),
      .H_BACK    (H_BACK),
      .V_VISIBLE (V_VISIBLE),
      .V_FRONT   (V_FRONT),
      .V_SYNC    (V_SYNC),
      .V_BACK    (V_BACK)
   ) u_text_scan (
      .clk       (clk),
      .arst_n    (arst_n),
      .buf_index (txt_index),
      .buf_wdata (txt_data),
      .buf_be    (txt_be),
      .buf_we    (txt_we),
      .vga_rgb   (vga_rgb),
      .vga_hsync (vga_hsync),
      .vga_vsync (vga_vsync)
   );

endmodule

/* rtl/sram.sv */
`timescale 1ns/10ps

module sram
   import soc_pkg::*;
#(
   parameter int WORDS_LOG2 = 13
) (
   input  logic                  clk,
   input  logic [WORDS_LOG2-1:0] wr_index,
   input  data_t                 wr_data,
   input  strb_t                 wr_be,
   input  logic                  wr_en,
   input  logic [WORDS_LOG2-1:0] rd_index,
   input  logic                  rd_en,
   output data_t                 rd_data
);

   data_t mem [2**WORDS_LOG2];

   always_ff @(posedge clk) begin
      if (wr_en) begin
         for (int b = 0; b < $bits(strb_t); b++) begin
            if (wr_be[b])
               mem[wr_index][8*b +: 8] <= wr_data[8*b +: 8];
         end
      end
      if (rd_en)
         rd_data <= mem[rd_index];
   end

endmodule

/* rtl/sram_read_port.sv */
`timescale 1ns/10ps

module sram_read_port
   import soc_pkg::*;
#(
   parameter int INDEX_BITS = 13
) (
   input  logic                  clk,
   input  logic                  arst_n,
   input  addr_t                 araddr,
   input  logic                  arvalid,
   output logic                  arready,
   output data_t                 rdata,
   output resp_t                 rresp,
   output logic                  rvalid,
   input  logic                  rready,
   output logic [INDEX_BITS-1:0] mem_index,
   output logic                  mem_re,
   input  data_t                 mem_rdata
);

   logic fetch_q;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         arready <= 1'b0;
         fetch_q <= 1'b0;
         rvalid  <= 1'b0;
      end else begin
         arready <= arvalid && !arready && !fetch_q && !rvalid;
         fetch_q <= mem_re;
         if (fetch_q)
            rvalid <= 1'b1;
         else if (rready)
            rvalid <= 1'b0;
      end
   end

   // memory word is out one cycle after mem_re
   always_ff @(posedge clk) begin
      if (fetch_q)
         rdata <= mem_rdata;
   end

   assign mem_re    = arready && arvalid;
   assign mem_index = araddr[INDEX_BITS+1:2];
   assign rresp     = RESP_OKAY;

endmodule

/* rtl/sram_write_port.sv */
`timescale 1ns/10ps

module sram_write_port
   import soc_pkg::*;
#(
   parameter int INDEX_BITS = 13
) (
   input  logic                  clk,
   input  logic                  arst_n,
   input  addr_t                 awaddr,
   input  logic                  awvalid,
   output logic                  awready,
   input  data_t                 wdata,
   input  strb_t                 wstrb,
   input  logic                  wvalid,
   output logic                  wready,
   output resp_t                 bresp,
   output logic                  bvalid,
   input  logic                  bready,
   output logic [INDEX_BITS-1:0] mem_index,
   output data_t                 mem_wdata,
   output strb_t                 mem_be,
   output logic                  mem_we
);

   logic accept_q;

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         accept_q <= 1'b0;
         bvalid   <= 1'b0;
      end else begin
         // one ready pulse per write, none while a response waits
         accept_q <= awvalid && wvalid && !accept_q && !bvalid;
         if (mem_we)
            bvalid <= 1'b1;
         else if (bready)
            bvalid <= 1'b0;
      end
   end

   assign awready = accept_q;
   assign wready  = accept_q;

   // write lands on the handshake edge
   assign mem_we    = accept_q && awvalid && wvalid;
   assign mem_index = awaddr[INDEX_BITS+1:2];
   assign mem_wdata = wdata;
   assign mem_be    = wstrb;

   assign bresp = RESP_OKAY;

endmodule

/* rtl/vga_text_scan.sv */
`timescale 1ns/10ps

module vga_text_scan
   import soc_pkg::*;
#(
   parameter int  COLS      = 80,
   parameter int  ROWS      = 25,
   parameter int  CELL_W    = 8,
   parameter int  CELL_H    = 16,
   parameter int  H_VISIBLE = 640,
   parameter int  H_FRONT   = 16,
   parameter int  H_SYNC    = 96,
   parameter int  H_BACK    = 48,
   parameter int  V_VISIBLE = 480,
   parameter int  V_FRONT   = 10,
   parameter int  V_SYNC    = 2,
   parameter int  V_BACK    = 33,
   localparam int BUF_BITS  = TEXT_ADDR_BITS - 2
) (
   input  logic                clk,
   input  logic                arst_n,
   input  logic [BUF_BITS-1:0] buf_index,
   input  data_t               buf_wdata,
   input  strb_t               buf_be,
   input  logic                buf_we,
   output rgb_t                vga_rgb,
   output logic                vga_hsync,
   output logic                vga_vsync
);

   localparam int X_BITS = $clog2(H_VISIBLE + H_FRONT + H_SYNC + H_BACK);
   localparam int Y_BITS = $clog2(V_VISIBLE + V_FRONT + V_SYNC + V_BACK);

   logic [X_BITS-1:0]   pix_x;
   logic [Y_BITS-1:0]   pix_y;
   logic                hsync;
   logic                vsync;
   logic                visible;
   logic [X_BITS-1:0]   col;
   logic [Y_BITS-1:0]   row;
   logic                in_grid;
   logic                in_grid_q;
   logic [BUF_BITS-1:0] cell_index;
   data_t               cell_word;
   logic                hsync_q;
   logic                vsync_q;

   vga_timing #(
      .H_VISIBLE (H_VISIBLE),
      .H_FRONT   (H_FRONT),
      .H_SYNC    (H_SYNC),
      .H_BACK    (H_BACK),
      .V_VISIBLE (V_VISIBLE),
      .V_FRONT   (V_FRONT),
      .V_SYNC    (V_SYNC),
      .V_BACK    (V_BACK)
   ) u_timing (
      .clk     (clk),
      .arst_n  (arst_n),
      .pix_x   (pix_x),
      .pix_y   (pix_y),
      .hsync   (hsync),
      .vsync   (vsync),
      .visible (visible)
   );

   // pixel to cell
   assign col        = X_BITS'(pix_x / CELL_W);
   assign row        = Y_BITS'(pix_y / CELL_H);
   assign in_grid    = visible && (col < COLS) && (row < ROWS);
   assign cell_index = BUF_BITS'(row * COLS + col);

   sram #(.WORDS_LOG2(BUF_BITS)) u_text_buf (
      .clk      (clk),
      .wr_index (buf_index),
      .wr_data  (buf_wdata),
      .wr_be    (buf_be),
      .wr_en    (buf_we),
      .rd_index (cell_index),
      .rd_en    (in_grid),
      .rd_data  (cell_word)
   );

   // two stages, buffer read then colour register
   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         in_grid_q <= 1'b0;
         hsync_q   <= 1'b1;
         vsync_q   <= 1'b1;
         vga_hsync <= 1'b1;
         vga_vsync <= 1'b1;
         vga_rgb   <= '0;
      end else begin
         in_grid_q <= in_grid;
         hsync_q   <= hsync;
         vsync_q   <= vsync;
         vga_hsync <= hsync_q;
         vga_vsync <= vsync_q;
         vga_rgb   <= in_grid_q ? cell_word[10:8] : '0;
      end
   end

endmodule

/* rtl/vga_timing.sv */
`timescale 1ns/10ps

module vga_timing #(
   parameter int  H_VISIBLE = 640,
   parameter int  H_FRONT   = 16,
   parameter int  H_SYNC    = 96,
   parameter int  H_BACK    = 48,
   parameter int  V_VISIBLE = 480,
   parameter int  V_FRONT   = 10,
   parameter int  V_SYNC    = 2,
   parameter int  V_BACK    = 33,
   localparam int H_TOTAL   = H_VISIBLE + H_FRONT + H_SYNC + H_BACK,
   localparam int V_TOTAL   = V_VISIBLE + V_FRONT + V_SYNC + V_BACK,
   localparam int X_BITS    = $clog2(H_TOTAL),
   localparam int Y_BITS    = $clog2(V_TOTAL)
) (
   input  logic              clk,
   input  logic              arst_n,
   output logic [X_BITS-1:0] pix_x,
   output logic [Y_BITS-1:0] pix_y,
   output logic              hsync,
   output logic              vsync,
   output logic              visible
);

   always_ff @(posedge clk or negedge arst_n) begin
      if (!arst_n) begin
         pix_x <= '0;
         pix_y <= '0;
      end else if (pix_x == X_BITS'(H_TOTAL - 1)) begin
         pix_x <= '0;
         pix_y <= (pix_y == Y_BITS'(V_TOTAL - 1)) ? '0 : pix_y + 1'b1;
      end else begin
         pix_x <= pix_x + 1'b1;
      end
   end

   // sync pulses sit after the front porch, active low
   assign hsync = !((pix_x >= H_VISIBLE + H_FRONT) &&
                    (pix_x < H_VISIBLE + H_FRONT + H_SYNC));
   assign vsync = !((pix_y >= V_VISIBLE + V_FRONT) &&
                    (pix_y < V_VISIBLE + V_FRONT + V_SYNC));

   assign visible = (pix_x < H_VISIBLE) && (pix_y < V_VISIBLE);

endmodule

/* sim.f */
rtl/soc_pkg.sv
rtl/sram.sv
rtl/sram_write_port.sv
rtl/sram_read_port.sv
rtl/bus_decoder.sv
rtl/vga_timing.sv
rtl/vga_text_scan.sv
rtl/soc_top.sv
tests/tb_soc.sv

/* tests/tb_soc.sv */
`timescale 1ns/10ps

module tb_soc
   import soc_pkg::*;
();

   localparam int COLS      = 4;
   localparam int ROWS      = 2;
   localparam int CELL_W    = 2;
   localparam int CELL_H    = 2;
   localparam int H_VISIBLE = 10;
   localparam int H_FRONT   = 2;
   localparam int H_SYNC    = 3;
   localparam int H_BACK    = 2;
   localparam int V_VISIBLE = 6;
   localparam int V_FRONT   = 1;
   localparam int V_SYNC    = 2;
   localparam int V_BACK    = 1;
   localparam int H_TOTAL   = H_VISIBLE + H_FRONT + H_SYNC + H_BACK;
   localparam int V_TOTAL   = V_VISIBLE + V_FRONT + V_SYNC + V_BACK;
   localparam int FRAME     = H_TOTAL * V_TOTAL;

   // 64 + 24 + 5 + 16 + 8 bus transactions over the five tests
   localparam int N_TRANSACTIONS = 117;
   localparam int CYCLE_LIMIT    = 50 * N_TRANSACTIONS + 3 * FRAME;
   localparam int HS_LIMIT       = 16;

   logic  clk;
   logic  arst_n;
   addr_t awaddr;
   logic  awvalid;
   logic  awready;
   data_t wdata;
   strb_t wstrb;
   logic  wvalid;
   logic  wready;
   resp_t bresp;
   logic  bvalid;
   logic  bready;
   addr_t araddr;
   logic  arvalid;
   logic  arready;
   data_t rdata;
   resp_t rresp;
   logic  rvalid;
   logic  rready;
   rgb_t  vga_rgb;
   logic  vga_hsync;
   logic  vga_vsync;

   logic [31:0] rng_state = 32'h75edf652;
   int          errors = 0;
   int          errors_at_start = 0;
   int          checks = 0;
   int          cycle_count = 0;
   int          pix_cycle = 0;
   int          video_checked = 0;
   bit          video_check_on = 0;
   data_t       ram_model [int];
   data_t       text_model [COLS*ROWS];
   addr_t       test_addr [32];

   soc_top #(
      .COLS      (COLS),
      .ROWS      (ROWS),
      .CELL_W    (CELL_W),
      .CELL_H    (CELL_H),
      .H_VISIBLE (H_VISIBLE),
      .H_FRONT   (H_FRONT),
      .H_SYNC    (H_SYNC),
      .H_BACK    (H_BACK),
      .V_VISIBLE (V_VISIBLE),
      .V_FRONT   (V_FRONT),
      .V_SYNC    (V_SYNC),
      .V_BACK    (V_BACK)
   ) i_dut (
      .clk       (clk),
      .arst_n    (arst_n),
      .awaddr    (awaddr),
      .awvalid   (awvalid),
      .awready   (awready),
      .wdata     (wdata),
      .wstrb     (wstrb),
      .wvalid    (wvalid),
      .wready    (wready),
      .bresp     (bresp),
      .bvalid    (bvalid),
      .bready    (bready),
      .araddr    (araddr),
      .arvalid   (arvalid),
      .arready   (arready),
      .rdata     (rdata),
      .rresp     (rresp),
      .rvalid    (rvalid),
      .rready    (rready),
      .vga_rgb   (vga_rgb),
      .vga_hsync (vga_hsync),
      .vga_vsync (vga_vsync)
   );

   initial begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   function automatic logic [31:0] xorshift32(input logic [31:0] s);
      logic [31:0] v;
      v = s;
      v = v ^ (v << 13);
      v = v ^ (v >> 17);
      v = v ^ (v << 5);
      return v;
   endfunction

   function automatic logic [31:0] next_random();
      rng_state = xorshift32(rng_state);
      return rng_state;
   endfunction

   // word after a byte-enabled write
   function automatic data_t merge_bytes(input data_t old, input data_t new_data,
                                         input strb_t strb);
      data_t r;
      r = old;
      for (int b = 0; b < 4; b++) begin
         if (strb[b])
            r[8*b +: 8] = new_data[8*b +: 8];
      end
      return r;
   endfunction

   // {hsync, vsync, rgb} for the k-th cycle after reset release
   function automatic logic [4:0] expected_video(input int k);
      int   p;
      int   x;
      int   y;
      logic hs;
      logic vs;
      rgb_t rgb;
      if (k < 2)
         return {1'b1, 1'b1, 3'b000};
      p   = (k - 2) % FRAME;
      x   = p % H_TOTAL;
      y   = p / H_TOTAL;
      hs  = !(x >= H_VISIBLE + H_FRONT && x < H_VISIBLE + H_FRONT + H_SYNC);
      vs  = !(y >= V_VISIBLE + V_FRONT && y < V_VISIBLE + V_FRONT + V_SYNC);
      rgb = '0;
      if (x < H_VISIBLE && y < V_VISIBLE && x / CELL_W < COLS && y / CELL_H < ROWS)
         rgb = text_model[(y / CELL_H) * COLS + x / CELL_W][10:8];
      return {hs, vs, rgb};
   endfunction

   task automatic check_data(input string name, input data_t expected, input data_t actual);
      checks++;
      if (actual !== expected) begin
         $display("mismatch %s: expected %h, got %h", name, expected, actual);
         errors++;
      end
   endtask

   task automatic check_resp(input string name, input resp_t expected, input resp_t actual);
      checks++;
      if (actual !== expected) begin
         $display("mismatch %s: expected %h, got %h", name, expected, actual);
         errors++;
      end
   endtask

   task automatic check_rgb(input string name, input rgb_t expected, input rgb_t actual);
      checks++;
      if (actual !== expected) begin
         $display("mismatch %s at cycle %0d: expected %h, got %h",
                  name, pix_cycle, expected, actual);
         errors++;
      end
   endtask

   task automatic check_bit(input string name, input logic expected, input logic actual);
      checks++;
      if (actual !== expected) begin
         $display("mismatch %s: expected %h, got %h", name, expected, actual);
         errors++;
      end
   endtask

   task automatic protocol_error(input string what);
      $display("error: %s", what);
      errors++;
   endtask

   task automatic finish_test(input int num, input string name);
      $display("test %0d %s: %0d errors", num, name, errors - errors_at_start);
      errors_at_start = errors;
   endtask

   task automatic bus_write(input addr_t addr, input data_t data, input strb_t strb,
                            input int stall, output resp_t resp);
      int waited;
      bit ok;
      resp = RESP_OKAY;
      ok   = 1'b1;
      @(posedge clk);
      awaddr  <= addr;
      wdata   <= data;
      wstrb   <= strb;
      awvalid <= 1'b1;
      wvalid  <= 1'b1;
      waited = 0;
      @(negedge clk);
      while (!awready && waited < HS_LIMIT) begin
         @(negedge clk);
         waited++;
      end
      if (!awready) begin
         protocol_error($sformatf("write to %h was never accepted", addr));
         ok = 1'b0;
      end else begin
         check_bit("wready", 1'b1, wready);
      end
      @(posedge clk);
      awvalid <= 1'b0;
      wvalid  <= 1'b0;
      if (ok) begin
         @(negedge clk);
         if (awready || wready)
            protocol_error("awready or wready stayed high after the write transfer");
         waited = 0;
         while (!bvalid && waited < HS_LIMIT) begin
            @(negedge clk);
            waited++;
         end
         if (!bvalid) begin
            protocol_error($sformatf("no write response for %h", addr));
            ok = 1'b0;
         end
      end
      if (ok) begin
         resp = bresp;
         // response must hold while bready is low
         repeat (stall) begin
            @(negedge clk);
            check_bit("bvalid", 1'b1, bvalid);
            check_resp("bresp", resp, bresp);
         end
         @(posedge clk);
         bready <= 1'b1;
         @(posedge clk);
         bready <= 1'b0;
         @(negedge clk);
         if (bvalid)
            protocol_error("bvalid still high after bready accepted the response");
      end
   endtask

   task automatic bus_read(input addr_t addr, input int stall,
                           output data_t data, output resp_t resp);
      int waited;
      bit ok;
      data = '0;
      resp = RESP_OKAY;
      ok   = 1'b1;
      @(posedge clk);
      araddr  <= addr;
      arvalid <= 1'b1;
      waited = 0;
      @(negedge clk);
      while (!arready && waited < HS_LIMIT) begin
         @(negedge clk);
         waited++;
      end
      if (!arready) begin
         protocol_error($sformatf("read of %h was never accepted", addr));
         ok = 1'b0;
      end
      @(posedge clk);
      arvalid <= 1'b0;
      if (ok) begin
         @(negedge clk);
         if (arready)
            protocol_error("arready stayed high after the read address transfer");
         waited = 0;
         while (!rvalid && waited < HS_LIMIT) begin
            @(negedge clk);
            waited++;
         end
         if (!rvalid) begin
            protocol_error($sformatf("no read data for %h", addr));
            ok = 1'b0;
         end
      end
      if (ok) begin
         data = rdata;
         resp = rresp;
         repeat (stall) begin
            @(negedge clk);
            check_bit("rvalid", 1'b1, rvalid);
            check_data("rdata", data, rdata);
            check_resp("rresp", resp, rresp);
         end
         @(posedge clk);
         rready <= 1'b1;
         @(posedge clk);
         rready <= 1'b0;
         @(negedge clk);
         if (rvalid)
            protocol_error("rvalid still high after rready accepted the read data");
      end
   endtask

   task automatic ram_write(input addr_t addr, input data_t data, input strb_t strb,
                            input int stall);
      resp_t resp;
      int    idx;
      idx = addr[RAM_ADDR_BITS-1:2];
      bus_write(addr, data, strb, stall, resp);
      check_resp("bresp", RESP_OKAY, resp);
      ram_model[idx] = merge_bytes(ram_model.exists(idx) ? ram_model[idx] : '0, data, strb);
   endtask

   task automatic ram_check(input addr_t addr, input int stall);
      data_t data;
      resp_t resp;
      int    idx;
      idx = addr[RAM_ADDR_BITS-1:2];
      bus_read(addr, stall, data, resp);
      check_resp("rresp", RESP_OKAY, resp);
      check_data("rdata", ram_model[idx], data);
   endtask

   always @(posedge clk) begin
      cycle_count++;
      if (cycle_count >= CYCLE_LIMIT) begin
         $display("error: run did not finish within %0d cycles", CYCLE_LIMIT);
         $display("Simulation failed");
         $finish;
      end
   end

   // video outputs checked mid-cycle against the model
   always @(negedge clk) begin
      logic [4:0] exp_video;
      if (!arst_n) begin
         pix_cycle = 0;
      end else begin
         // reset values show for the first two cycles
         if (video_check_on || pix_cycle < 2) begin
            exp_video = expected_video(pix_cycle);
            check_bit("vga_hsync", exp_video[4], vga_hsync);
            check_bit("vga_vsync", exp_video[3], vga_vsync);
            check_rgb("vga_rgb", exp_video[2:0], vga_rgb);
         end
         if (video_check_on)
            video_checked++;
         pix_cycle++;
      end
   end

   initial begin
      logic [31:0] r;
      data_t       data;
      resp_t       resp;
      strb_t       strb;
      arst_n  = 1'b0;
      awaddr  = '0;
      awvalid = 1'b0;
      wdata   = '0;
      wstrb   = '0;
      wvalid  = 1'b0;
      bready  = 1'b0;
      araddr  = '0;
      arvalid = 1'b0;
      rready  = 1'b0;
      repeat (2) @(posedge clk);
      arst_n <= 1'b1;

      for (int i = 0; i < 32; i++) begin
         test_addr[i] = RAM_BASE | (next_random() & 32'h7ffc);
         ram_write(test_addr[i], next_random(), 4'hf, 0);
      end
      for (int i = 0; i < 32; i++)
         ram_check(test_addr[i], 0);
      finish_test(1, "random ram write and read");

      for (int i = 0; i < 8; i++)
         ram_write(RAM_BASE + 32'h100 + 4 * i, 32'ha5a50000 | i, 4'hf, 0);
      for (int i = 0; i < 8; i++) begin
         r    = next_random();
         strb = r[3:0];
         if (strb == 4'hf)
            strb = 4'h6;
         else if (strb == 4'h0)
            strb = 4'h9;
         ram_write(RAM_BASE + 32'h100 + 4 * i, next_random(), strb, 0);
      end
      for (int i = 0; i < 8; i++)
         ram_check(RAM_BASE + 32'h100 + 4 * i, 0);
      finish_test(2, "partial strobe writes");

      // 1c008010 lies just past the ram window and shares its low bits with 1c000010
      ram_write(RAM_BASE + 32'h10, 32'hcafef00d, 4'hf, 0);
      bus_write(32'h1c008010, 32'hdeadbeef, 4'hf, 0, resp);
      check_resp("bresp", RESP_DECERR, resp);
      bus_read(32'h1c008010, 0, data, resp);
      check_resp("rresp", RESP_DECERR, resp);
      check_data("rdata", '0, data);
      bus_read(TEXT_BASE + 32'h8, 0, data, resp);
      check_resp("rresp", RESP_OKAY, resp);
      check_data("rdata", '0, data);
      ram_check(RAM_BASE + 32'h10, 0);
      finish_test(3, "unmapped and text region access");

      for (int i = 0; i < 8; i++) begin
         test_addr[i] = RAM_BASE | (next_random() & 32'h7ffc);
         r = next_random();
         ram_write(test_addr[i], next_random(), 4'hf, r[2:0]);
         ram_check(test_addr[i], r[6:4]);
      end
      finish_test(4, "response back-pressure");

      for (int c = 0; c < COLS * ROWS; c++) begin
         text_model[c] = next_random();
         bus_write(TEXT_BASE + 4 * c, text_model[c], 4'hf, 0, resp);
         check_resp("bresp", RESP_OKAY, resp);
      end
      @(posedge clk);
      video_check_on = 1'b1;
      while (video_checked < 2 * FRAME)
         @(negedge clk);
      @(posedge clk);
      video_check_on = 1'b0;
      finish_test(5, "text frame scan");

      $display("tests 5, checks %0d, errors %0d", checks, errors);
      if (errors == 0)
         $display("Simulation passed");
      else
         $display("Simulation failed");
      $finish;
   end

endmodule
